//--- common/mac_pkg.sv
package mac_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;   // Sent MSB first
  typedef logic [15:0] ethertype_t;
  typedef logic [31:0] crc_t;
  typedef logic [10:0] len_t;        // Payload byte count

  localparam int        PREAMBLE_LEN  = 7;
  localparam byte_t     SFD_BYTE      = 8'hd5;
  localparam byte_t     PREAMBLE_BYTE = 8'h55;
  localparam int        HDR_LEN       = 14;  // dst + src + ethertype
  localparam int        MIN_PAYLOAD   = 46;
  localparam int        IFG_LEN       = 12;
  localparam int        FCS_LEN       = 4;
  localparam int        RX_DLY_LEN    = FCS_LEN + 1;
  localparam crc_t      CRC_POLY      = 32'hedb88320; // 04c11db7 bit reversed
  localparam crc_t      CRC_PRESET    = 32'hffffffff;
  localparam crc_t      CRC_RESIDUE   = 32'hdebb20e3; // Remainder after a good FCS
  localparam mac_addr_t BROADCAST_ADDR = 48'hffff_ffff_ffff;

  typedef struct packed {
    mac_addr_t  dst;
    ethertype_t ethertype;
  } tx_hdr_t;

  typedef struct packed {
    byte_t data;
    logic  last;
  } pl_byte_t;

  typedef struct packed {
    byte_t data;
    logic  crc_en;  // Byte is covered by the FCS
    logic  last;    // Final byte ahead of the FCS
  } frm_byte_t;

  typedef struct packed {
    byte_t d;
    logic  v;
  } phy_t;

  typedef struct packed {
    mac_addr_t  dst;
    mac_addr_t  src;
    ethertype_t ethertype;
  } rx_hdr_t;

  typedef enum logic [2:0] {
    tx_idle, tx_preamble, tx_header, tx_payload, tx_pad, tx_wait_fcs, tx_gap
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_idle, rx_preamble, rx_header, rx_payload, rx_drop
  } rx_state_t;

endpackage

//--- filelist.f
common/mac_pkg.sv
src/crc32.sv
mac_tx/mac_tx_framer.sv
mac_tx/mac_tx_fcs.sv
mac_rx/mac_rx_parser.sv
src/mac_top.sv
verification/mac_tb.sv

//--- mac_rx/mac_rx_parser.sv
`timescale 1ns/10ps

module mac_rx_parser import mac_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  mac_addr_t station_addr,
  input  phy_t      phy_rx,
  output rx_hdr_t   rx_hdr,
  output logic      rx_hdr_valid,
  output pl_byte_t  rx_out,
  output logic      rx_valid,
  output logic      rx_fcs_ok
);

  rx_state_t                state;
  logic [3:0]               idx;
  logic [2:0]               fill;     // Bytes held in the delay line
  byte_t [RX_DLY_LEN-1:0]   dly;
  logic [HDR_LEN*8-1:0]     hdr_sr;
  logic [HDR_LEN*8-1:0]     hdr_next;
  rx_hdr_t                  hdr_cand;
  logic                     addr_hit;
  logic                     dly_full;
  logic                     crc_clear;
  logic                     crc_en;
  logic                     residue_ok;

  assign hdr_next  = {hdr_sr[HDR_LEN*8-9:0], phy_rx.d};
  assign hdr_cand  = rx_hdr_t'(hdr_next);
  assign addr_hit  = (hdr_cand.dst == station_addr) || (hdr_cand.dst == BROADCAST_ADDR);
  assign dly_full  = (fill == 3'(RX_DLY_LEN));
  assign crc_clear = (state == rx_idle) || (state == rx_preamble);
  assign crc_en    = phy_rx.v && ((state == rx_header) || (state == rx_payload));

  crc32 u_crc (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .clear      (crc_clear),
    .en         (crc_en),
    .d          (phy_rx.d),
    .crc        (),
    .residue_ok (residue_ok)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state        <= rx_idle;
      idx          <= '0;
      fill         <= '0;
      rx_hdr_valid <= 1'b0;
      rx_valid     <= 1'b0;
      rx_fcs_ok    <= 1'b0;
    end else begin
      rx_hdr_valid <= 1'b0;
      rx_valid     <= 1'b0;
      rx_fcs_ok    <= 1'b0;
      case (state)
        rx_idle: if (phy_rx.v) begin
          state <= (phy_rx.d == PREAMBLE_BYTE) ? rx_preamble : rx_drop;
        end

        rx_preamble: begin
          if (!phy_rx.v) begin
            state <= rx_idle;
          end else if (phy_rx.d == SFD_BYTE) begin
            idx   <= '0;
            state <= rx_header;
          end else if (phy_rx.d != PREAMBLE_BYTE) begin
            state <= rx_drop;
          end
        end

        rx_header: begin
          if (!phy_rx.v) begin
            state <= rx_idle;  // Runt frame is not reported
          end else begin
            hdr_sr <= hdr_next;
            idx    <= idx + 1'b1;
            if (idx == 4'(HDR_LEN - 1)) begin
              fill <= '0;
              if (addr_hit) begin
                rx_hdr       <= hdr_cand;
                rx_hdr_valid <= 1'b1;
                state        <= rx_payload;
              end else begin
                state <= rx_drop;
              end
            end
          end
        end

        rx_payload: begin
          rx_out.data <= dly[RX_DLY_LEN-1];
          rx_valid    <= dly_full;
          if (phy_rx.v) begin
            dly         <= {dly[RX_DLY_LEN-2:0], phy_rx.d};
            rx_out.last <= 1'b0;
            if (!dly_full) fill <= fill + 1'b1;
          end else begin
            // Oldest byte is the last payload byte and the rest is FCS
            rx_out.last <= 1'b1;
            rx_fcs_ok   <= dly_full && residue_ok;
            state       <= rx_idle;
          end
        end

        rx_drop: if (!phy_rx.v) state <= rx_idle;

        default: state <= rx_idle;
      endcase
    end
  end

  // Only the flagged final byte comes out after the payload state
  a_rx_valid_in_payload: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_valid |-> (state == rx_payload) || (state == rx_idle && rx_out.last));

endmodule

//--- mac_tx/mac_tx_fcs.sv
`timescale 1ns/10ps

module mac_tx_fcs import mac_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  frm_byte_t frm,
  input  logic      frm_valid,
  output logic      frm_ready,
  output phy_t      phy_tx
);

  logic [2:0] fcs_cnt;   // FCS bytes still to send
  logic [1:0] fcs_idx;
  logic       accept;
  logic       crc_clear;
  logic       crc_en;
  logic       in_frame;
  crc_t       crc;

  assign frm_ready = (fcs_cnt == '0);
  assign accept    = frm_valid && frm_ready;
  assign fcs_idx   = 2'(3'(FCS_LEN) - fcs_cnt);
  assign crc_en    = accept && frm.crc_en;
  assign crc_clear = (fcs_cnt == 3'd1);  // Along with the final FCS byte

  crc32 u_crc (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .clear      (crc_clear),
    .en         (crc_en),
    .d          (frm.data),
    .crc        (crc),
    .residue_ok ()
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      phy_tx.v <= 1'b0;
      fcs_cnt  <= '0;
      in_frame <= 1'b0;
    end else begin
      if (accept) begin
        phy_tx   <= '{d: frm.data, v: 1'b1};
        in_frame <= !frm.last;
        if (frm.last) fcs_cnt <= 3'(FCS_LEN);
      end else if (fcs_cnt != '0) begin
        phy_tx  <= '{d: crc[8*fcs_idx +: 8], v: 1'b1};  // LSB first
        fcs_cnt <= fcs_cnt - 1'b1;
      end else begin
        phy_tx.v <= 1'b0;
      end
    end
  end

  // A hole in the framed bytes would break v on the wire
  a_frm_contiguous: assert property (@(posedge clk) disable iff (fsm_rst)
    in_frame |-> frm_valid);

endmodule

//--- mac_tx/mac_tx_framer.sv
`timescale 1ns/10ps

module mac_tx_framer import mac_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  mac_addr_t station_addr,
  input  tx_hdr_t   tx_hdr,
  input  pl_byte_t  tx_in,
  input  logic      tx_valid,
  output logic      tx_ready,
  output frm_byte_t frm,
  output logic      frm_valid,
  input  logic      frm_ready
);

  tx_state_t            state;
  logic [4:0]           idx;
  len_t                 len;
  len_t                 len_nxt;
  logic [HDR_LEN*8-1:0] hdr_sr;   // dst, src, ethertype
  pl_byte_t             hold_q;   // First byte, taken at the start handshake
  logic                 hold_v;
  pl_byte_t             pl;
  logic                 pl_ok;
  logic                 adv;
  logic                 take;

  assign adv     = !frm_valid || frm_ready;
  assign take    = tx_valid && tx_ready;
  assign pl      = hold_v ? hold_q : tx_in;
  assign pl_ok   = hold_v || take;
  assign len_nxt = len + 1'b1;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= tx_idle;
      tx_ready  <= 1'b0;
      frm_valid <= 1'b0;
      idx       <= '0;
      len       <= '0;
      hold_v    <= 1'b0;
    end else begin
      case (state)
        tx_idle: begin
          if (take) begin
            tx_ready  <= 1'b0;
            hold_q    <= tx_in;
            hold_v    <= 1'b1;
            hdr_sr    <= {tx_hdr.dst, station_addr, tx_hdr.ethertype};
            frm       <= '{data: PREAMBLE_BYTE, crc_en: 1'b0, last: 1'b0};
            frm_valid <= 1'b1;
            idx       <= 5'd1;
            len       <= '0;
            state     <= tx_preamble;
          end else if (tx_valid) begin
            tx_ready <= 1'b1;  // One cycle window for the first byte
          end
        end

        tx_preamble: if (adv) begin
          if (idx == 5'(PREAMBLE_LEN)) begin
            frm   <= '{data: SFD_BYTE, crc_en: 1'b0, last: 1'b0};
            idx   <= '0;
            state <= tx_header;
          end else begin
            frm <= '{data: PREAMBLE_BYTE, crc_en: 1'b0, last: 1'b0};
            idx <= idx + 1'b1;
          end
        end

        tx_header: if (adv) begin
          frm    <= '{data: hdr_sr[HDR_LEN*8-1 -: 8], crc_en: 1'b1, last: 1'b0};
          hdr_sr <= hdr_sr << 8;
          idx    <= idx + 1'b1;
          if (idx == 5'(HDR_LEN - 1)) state <= tx_payload;
        end

        tx_payload: if (adv) begin
          frm_valid <= pl_ok;
          if (pl_ok) begin
            frm <= '{data: pl.data, crc_en: 1'b1,
                     last: pl.last && (len_nxt >= len_t'(MIN_PAYLOAD))};
            len      <= len_nxt;
            hold_v   <= 1'b0;
            tx_ready <= !pl.last;
            if (pl.last) begin
              state <= (len_nxt >= len_t'(MIN_PAYLOAD)) ? tx_wait_fcs : tx_pad;
            end
          end
        end

        tx_pad: if (adv) begin
          frm <= '{data: 8'h00, crc_en: 1'b1, last: len_nxt == len_t'(MIN_PAYLOAD)};
          len <= len_nxt;
          if (len_nxt == len_t'(MIN_PAYLOAD)) state <= tx_wait_fcs;
        end

        tx_wait_fcs: if (frm_ready) begin  // Final byte goes this cycle
          frm_valid <= 1'b0;
          idx       <= '0;
          state     <= tx_gap;
        end

        tx_gap: if (frm_ready) begin  // Counts only once the FCS is out
          idx <= idx + 1'b1;
          if (idx == 5'(IFG_LEN - 1)) state <= tx_idle;
        end

        default: state <= tx_idle;
      endcase
    end
  end

  // Upper layer must keep the payload flowing, the PHY cannot pause
  a_payload_no_gap: assert property (@(posedge clk) disable iff (fsm_rst)
    (state == tx_payload && tx_ready) |-> tx_valid);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal -f filelist.f --top-module mac_tb -o mac_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mac_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

//--- src/crc32.sv
`timescale 1ns/10ps

module crc32 import mac_pkg::*; (
  input  logic  clk,
  input  logic  fsm_rst,
  input  logic  clear,
  input  logic  en,
  input  byte_t d,
  output crc_t  crc,
  output logic  residue_ok
);

  crc_t rem;

  // LSB first, one bit per step
  function automatic crc_t crc_byte(crc_t c, byte_t b);
    crc_t r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      if (r[0] ^ b[i]) begin
        r = (r >> 1) ^ CRC_POLY;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst || clear) begin
      rem <= CRC_PRESET;
    end else if (en) begin
      rem <= crc_byte(rem, d);
    end
  end

  assign crc        = ~rem;  // Ready to send, low byte first
  assign residue_ok = (rem == CRC_RESIDUE);

endmodule

//--- src/mac_top.sv
`timescale 1ns/10ps

module mac_top import mac_pkg::*; (
  input  logic      clk,
  input  logic      fsm_rst,
  input  mac_addr_t station_addr,
  input  tx_hdr_t   tx_hdr,
  input  pl_byte_t  tx_in,
  input  logic      tx_valid,
  output logic      tx_ready,
  output phy_t      phy_tx,
  input  phy_t      phy_rx,
  output rx_hdr_t   rx_hdr,
  output logic      rx_hdr_valid,
  output pl_byte_t  rx_out,
  output logic      rx_valid,
  output logic      rx_fcs_ok
);

  frm_byte_t frm;
  logic      frm_valid;
  logic      frm_ready;

  mac_tx_framer u_framer (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .station_addr (station_addr),
    .tx_hdr       (tx_hdr),
    .tx_in        (tx_in),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .frm          (frm),
    .frm_valid    (frm_valid),
    .frm_ready    (frm_ready)
  );

  mac_tx_fcs u_fcs (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .frm       (frm),
    .frm_valid (frm_valid),
    .frm_ready (frm_ready),
    .phy_tx    (phy_tx)
  );

  mac_rx_parser u_rx (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .station_addr (station_addr),
    .phy_rx       (phy_rx),
    .rx_hdr       (rx_hdr),
    .rx_hdr_valid (rx_hdr_valid),
    .rx_out       (rx_out),
    .rx_valid     (rx_valid),
    .rx_fcs_ok    (rx_fcs_ok)
  );

endmodule

//--- verification/mac_tb.sv
`timescale 1ns/10ps

module mac_tb import mac_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 4000;  // Ten frames of up to ~170 cycles with gaps, doubled
  localparam int PL_START       = PREAMBLE_LEN + 1 + HDR_LEN;  // Payload offset in a frame
  localparam int READY_GAP      = PL_START + 1;  // First take to second take

  logic      clk = 1'b0;
  logic      fsm_rst;
  mac_addr_t station_addr;
  tx_hdr_t   tx_hdr;
  pl_byte_t  tx_in;
  logic      tx_valid;
  logic      tx_ready;
  phy_t      phy_tx;
  phy_t      phy_rx;
  phy_t      drv_phy;
  logic      loop_en;
  rx_hdr_t   rx_hdr;
  logic      rx_hdr_valid;
  pl_byte_t  rx_out;
  logic      rx_valid;
  logic      rx_fcs_ok;

  byte_t   pl_mem [0:127];
  byte_t   exp_q[$];
  byte_t   tx_cap[$];
  int      tx_runs[$];
  byte_t   rx_cap[$];
  rx_hdr_t hdr_cap;
  int      hdr_cnt = 0;
  logic    rx_done = 1'b0;
  logic    rx_ok = 1'b0;
  int      run_len = 0;
  int      low_len = 0;
  logic    had_frame = 1'b0;
  int      cycle_cnt = 0;
  int      seed = 48016;

  always #5 clk = ~clk;

  assign phy_rx = loop_en ? phy_tx : drv_phy;  // Loopback unless the bench drives the PHY

  mac_top DUT (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .station_addr (station_addr),
    .tx_hdr       (tx_hdr),
    .tx_in        (tx_in),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .phy_tx       (phy_tx),
    .phy_rx       (phy_rx),
    .rx_hdr       (rx_hdr),
    .rx_hdr_valid (rx_hdr_valid),
    .rx_out       (rx_out),
    .rx_valid     (rx_valid),
    .rx_fcs_ok    (rx_fcs_ok)
  );

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
    assert (got === exp) else
      stop_fail($sformatf("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, got));
  endtask

  // Transmit side monitor with the inter-frame gap check
  always @(posedge clk) begin
    if (fsm_rst) begin
      run_len = 0;
      low_len = 0;
      had_frame = 1'b0;
    end else if (phy_tx.v) begin
      if (run_len == 0 && had_frame) begin
        assert (low_len >= IFG_LEN) else
          stop_fail($sformatf("[FAIL] t=%0t phy_tx.v low cycles expected >= %0d actual %0d",
                              $time, IFG_LEN, low_len));
      end
      tx_cap.push_back(phy_tx.d);
      run_len++;
    end else begin
      if (run_len != 0) begin
        tx_runs.push_back(run_len);
        had_frame = 1'b1;
        low_len = 0;
      end
      run_len = 0;
      low_len++;
    end
  end

  always @(posedge clk) begin
    if (rx_hdr_valid) begin
      hdr_cap = rx_hdr;
      hdr_cnt++;
    end
    if (rx_valid) begin
      rx_cap.push_back(rx_out.data);
      if (rx_out.last) begin
        rx_done = 1'b1;
        rx_ok   = rx_fcs_ok;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) stop_fail("Timeout: the tests did not finish in time");
  end

  // Reflected CRC-32 over the model frame from index first to the end
  function automatic crc_t crc_ref(input int first);
    crc_t c;
    c = 32'hffffffff;
    for (int i = first; i < exp_q.size(); i++) begin
      c = c ^ {24'h0, exp_q[i]};
      for (int b = 0; b < 8; b++) begin
        c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
      end
    end
    return ~c;
  endfunction

  task automatic build_frame(input mac_addr_t dst, input ethertype_t etype, input int n);
    logic [HDR_LEN*8-1:0] hdr;
    crc_t                 fcs;
    hdr = {dst, station_addr, etype};
    exp_q.delete();
    repeat (PREAMBLE_LEN) exp_q.push_back(PREAMBLE_BYTE);
    exp_q.push_back(SFD_BYTE);
    for (int i = HDR_LEN - 1; i >= 0; i--) exp_q.push_back(hdr[8*i +: 8]);
    for (int i = 0; i < n; i++) exp_q.push_back(pl_mem[i]);
    for (int i = n; i < MIN_PAYLOAD; i++) exp_q.push_back(8'h00);
    fcs = crc_ref(PREAMBLE_LEN + 1);
    for (int i = 0; i < FCS_LEN; i++) exp_q.push_back(fcs[8*i +: 8]);  // Low byte first
  endtask

  task automatic fill_payload(input int n);
    for (int i = 0; i < n; i++) pl_mem[i] = byte_t'($random(seed));
  endtask

  task automatic clear_capture();
    tx_cap.delete();
    tx_runs.delete();
    rx_cap.delete();
    hdr_cnt = 0;
    rx_done = 1'b0;
    rx_ok   = 1'b0;
  endtask

  // Pushes one payload through the upper-layer handshake
  task automatic send_frame(input mac_addr_t dst, input ethertype_t etype, input int n);
    int   sent;
    int   k;
    logic v_seen;
    sent = 0;
    k = 0;
    v_seen = 1'b0;
    tx_hdr   <= '{dst: dst, ethertype: etype};
    tx_in    <= '{data: pl_mem[0], last: n == 1};
    tx_valid <= 1'b1;
    while (sent < n) begin
      @(posedge clk);
      if (sent > 0) k++;
      if (sent > 0 && phy_tx.v && !v_seen) begin
        check_eq("phy_tx.v rise delay", k, 2);
        v_seen = 1'b1;
      end
      if (tx_valid && tx_ready) begin
        if (sent == 1) check_eq("tx_ready cycles to second take", k, READY_GAP);
        sent++;
        if (sent == n) begin
          tx_valid <= 1'b0;
        end else begin
          tx_in <= '{data: pl_mem[sent], last: sent == n - 1};
        end
      end
    end
  endtask

  task automatic check_tx(input int frame_len);
    while (tx_runs.size() < 1) @(posedge clk);
    check_eq("phy_tx.v run length", tx_runs[0], frame_len);
    for (int i = 0; i < frame_len; i++) begin
      check_eq($sformatf("phy_tx.d[%0d]", i), tx_cap[i], exp_q[i]);
    end
  endtask

  task automatic check_rx(input mac_addr_t dst, input ethertype_t etype, input logic fcs_good);
    int n_pl;
    n_pl = exp_q.size() - PL_START - FCS_LEN;
    while (!rx_done) @(posedge clk);
    check_eq("rx_hdr_valid pulses", hdr_cnt, 1);
    check_eq("rx_hdr", hdr_cap, {dst, station_addr, etype});
    check_eq("rx_out byte count", rx_cap.size(), n_pl);
    for (int i = 0; i < n_pl; i++) begin
      check_eq($sformatf("rx_out.data[%0d]", i), rx_cap[i], exp_q[PL_START + i]);
    end
    check_eq("rx_fcs_ok", rx_ok, fcs_good);
  endtask

  task automatic loop_frame(input mac_addr_t dst, input int n, input int frame_len);
    clear_capture();
    fill_payload(n);
    build_frame(dst, 16'h0800, n);
    send_frame(dst, 16'h0800, n);
    check_tx(frame_len);
    check_rx(dst, 16'h0800, 1'b1);
  endtask

  task automatic test_loopback();
    int n;
    repeat (3) begin
      n = 46 + int'($unsigned($random(seed)) % 55);
      loop_frame(station_addr, n, PL_START + n + FCS_LEN);
    end
  endtask

  task automatic test_filter();
    loop_frame(BROADCAST_ADDR, 50, PL_START + 50 + FCS_LEN);
    clear_capture();
    send_frame(station_addr ^ 48'h1, 16'h0800, 50);
    while (tx_runs.size() < 1) @(posedge clk);
    repeat (IFG_LEN) @(posedge clk);
    check_eq("rx_hdr_valid pulses for other address", hdr_cnt, 0);
    check_eq("rx_valid bytes for other address", rx_cap.size(), 0);
  endtask

  task automatic test_fcs_error();
    clear_capture();
    fill_payload(50);
    build_frame(station_addr, 16'h88b5, 50);
    exp_q[PL_START + 7] = exp_q[PL_START + 7] ^ 8'h40;  // Corrupt after the FCS is formed
    loop_en <= 1'b0;
    for (int i = 0; i < exp_q.size(); i++) begin
      drv_phy <= '{d: exp_q[i], v: 1'b1};
      @(posedge clk);
    end
    drv_phy <= '{d: 8'h00, v: 1'b0};
    check_rx(station_addr, 16'h88b5, 1'b0);
    loop_en <= 1'b1;
  endtask

  task automatic test_back_to_back();
    clear_capture();
    fill_payload(50);
    send_frame(station_addr, 16'h0800, 50);
    send_frame(station_addr, 16'h0806, 48);  // Queued while the first is on the wire
    while (tx_runs.size() < 2) @(posedge clk);
    check_eq("phy_tx.v run length frame 1", tx_runs[0], PL_START + 50 + FCS_LEN);
    check_eq("phy_tx.v run length frame 2", tx_runs[1], PL_START + 48 + FCS_LEN);
    repeat (2 * IFG_LEN) @(posedge clk);
  endtask

  initial begin
    fsm_rst      = 1'b1;
    station_addr = 48'h02_00_5e_10_20_30;
    tx_hdr       = '0;
    tx_in        = '0;
    tx_valid     = 1'b0;
    drv_phy      = '0;
    loop_en      = 1'b1;
    repeat (3) @(posedge clk);
    fsm_rst <= 1'b0;
    @(posedge clk);
    check_eq("tx_ready after reset", tx_ready, 0);
    check_eq("frm_valid after reset", DUT.frm_valid, 0);
    check_eq("phy_tx.v after reset", phy_tx.v, 0);
    check_eq("rx_valid after reset", rx_valid, 0);
    check_eq("rx_hdr_valid after reset", rx_hdr_valid, 0);
    check_eq("rx_fcs_ok after reset", rx_fcs_ok, 0);

    loop_frame(station_addr, 60, 86);  // Framing
    loop_frame(station_addr, 10, 72);  // Padding to the minimum payload
    test_loopback();
    test_filter();
    test_fcs_error();
    test_back_to_back();

    $display("all tests passed");
    $finish;
  end

endmodule
